// ==== files.f ====
+incdir+src
src/vic_pkg.sv
src/raster_timer.sv
src/video_delay.sv
src/bus_sequencer.sv
src/vic_registers.sv
src/pixel_unit.sv
src/vic_board_top.sv
bench/vic_assertions.sv
bench/vic_tb.sv

// ==== bench/vic_tb.sv ====
`default_nettype none

`include "vic_config.svh"

module vic_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import vic_pkg::*;

  localparam int FRAME_NS = `FRAME_LINES * `LINE_CYCLES * `CYCLE_TICKS * 40;

  logic clk_col4x_pal, rst_n, ce, rw, lp;
  logic addr_drive, data_drive;       // cpu owns adl / dbl
  logic [5:0] cpu_addr;
  logic [7:0] cpu_data;
  wire  [5:0] adl, adh, red, green, blue;
  wire  [7:0] dbl;
  wire  [3:0] dbh;
  wire clk_phi, aec, ras, cas, irq, ls245_addr_dir, ls245_data_dir, hsync, vsync, active;

  int errors = 0;
  int checks = 0;
  integer seed = 54;
  logic [4:0] m_tick;                 // beam model
  logic [5:0] m_cycle;
  logic [8:0] m_line;
  logic [3:0] border_m = 0, bg_m = 0, base_m = 0;
  logic den_m = 0;
  logic sync_chk = 0, pix_chk = 0;
  logic [7:0] next_byte, shown_byte;
  logic [3:0] next_col, shown_col;
  logic next_v = 0, shown_v = 0;
  logic [7:0] cell_m = 0;             // cell index the next fetch should carry
  logic [3:0] h1_idx, h2_idx;         // expected index, 1 and 2 clocks old
  logic [2:0] h1_sync, h2_sync;       // {hsync, vsync, active}
  logic [8:0] vs_line = 0;            // line count rebuilt from the sync pins
  logic prev_h = 0, prev_v = 0;

  // memory contents depend on every address bit
  function automatic logic [7:0] mem_byte(input logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  function automatic logic [3:0] mem_nib(input logic [11:0] a);
    return a[3:0] ^ a[7:4] ^ a[11:8] ^ 4'h3;
  endfunction

  assign adl = addr_drive ? cpu_addr : 6'bz;
  assign dbl = ls245_addr_dir ? mem_byte({adh, adl}) : (data_drive ? cpu_data : 8'bz);
  assign dbh = ls245_addr_dir ? mem_nib({adh, adl}) : 4'h0;

  vic_board_top UUT (.*);

  initial begin
    clk_col4x_pal = 0;
    forever #20 clk_col4x_pal = !clk_col4x_pal;
  end

  task automatic note_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    if (errors <= 20) $display("Fail %s got %h expected %h", name, got, exp);
  endtask

  always @(posedge clk_col4x_pal) begin // same wrap rules as the beam
    if (!rst_n) begin
      {m_tick, m_cycle, m_line} <= '0;
    end else if (m_tick != 5'(`CYCLE_TICKS - 1)) begin
      m_tick <= m_tick + 1;
    end else begin
      m_tick <= 0;
      m_cycle <= (m_cycle == 6'(`LINE_CYCLES - 1)) ? 6'd0 : m_cycle + 1;
      if (m_cycle == 6'(`LINE_CYCLES - 1))
        m_line <= (m_line == 9'(`FRAME_LINES - 1)) ? 9'd0 : m_line + 1;
    end
  end

  always @(negedge clk_col4x_pal) begin : video_model
    logic in_win;
    logic [3:0] e_idx;
    in_win = m_cycle >= `WIN_FIRST_CYCLE && m_cycle <= `WIN_LAST_CYCLE &&
             m_line >= `WIN_FIRST_LINE && m_line <= `WIN_LAST_LINE;
    if (sync_chk) begin
      checks++;
      if ({hsync, vsync, active} !== h2_sync) note_fail("sync", {hsync, vsync, active}, h2_sync);
    end
    if (pix_chk) begin
      checks++;
      if ({red, green, blue} !== palette[h2_idx]) note_fail("rgb", {red, green, blue},
                                                            palette[h2_idx]);
    end
    e_idx = (!shown_v || !den_m) ? border_m :
            (shown_byte[7 - m_tick[4:2]] ? shown_col : bg_m);  // msb first, 4 ticks each
    h2_idx = h1_idx;
    h1_idx = e_idx;
    h2_sync = h1_sync;
    h1_sync[2] = m_cycle >= `HSYNC_CYCLES;
    h1_sync[1] = m_line >= `VSYNC_LINES;
    h1_sync[0] = h1_sync[2] && h1_sync[1];
    if (m_tick == 0 && m_cycle == 0 && m_line == 0) cell_m = 0;  // frame start
    if (m_tick == 15 && in_win && den_m) begin  // memory answer for this cell
      checks++;
      if (adh[5:2] !== base_m) note_fail("adh_base", adh[5:2], base_m);
      if ({adh[1:0], adl} !== cell_m) note_fail("cell_idx", {adh[1:0], adl}, cell_m);
      if (ls245_addr_dir !== 1'b1) note_fail("ls245_addr_dir", ls245_addr_dir, 1);
      next_byte = mem_byte({adh, adl});
      next_col = mem_nib({adh, adl});
      next_v = 1;
      cell_m = cell_m + 1;
    end
    if (m_tick == 31) begin                       // shown during the next cycle
      {shown_byte, shown_col, shown_v} = {next_byte, next_col, next_v};
      next_v = 0;
    end
    if (prev_v && !vsync) vs_line = 0;
    else if (prev_h && !hsync) vs_line = vs_line + 1;
    prev_h = hsync;
    prev_v = vsync;
  end

  task automatic write_reg(input logic [5:0] a, input logic [7:0] d);
    @(posedge clk_phi);
    #2 {ce, rw, cpu_addr, cpu_data, addr_drive, data_drive} = {2'b00, a, d, 2'b11};
    @(negedge clk_phi);
    #2 {ce, rw, addr_drive, data_drive} = 4'b1100;
    case (a)                              // shadow of what the registers now hold
      `REG_BORDER: border_m = d[3:0];
      `REG_BG:     bg_m = d[3:0];
      `REG_BASE:   base_m = d[7:4];
      `REG_CTRL:   den_m = d[4];
      default: ;
    endcase
  endtask

  task automatic read_reg(input logic [5:0] a, output logic [7:0] d);
    @(posedge clk_phi);
    #2 {ce, rw, cpu_addr, addr_drive, data_drive} = {2'b01, a, 2'b10};
    repeat (14) @(posedge clk_col4x_pal);
    #2 d = dbl;                           // tick 30
    if (ls245_data_dir !== 1'b1) note_fail("ls245_data_dir", ls245_data_dir, 1);
    @(negedge clk_phi);
    #2 {ce, addr_drive} = 2'b10;
  endtask

  task automatic wait_pos(input int line, input int cycle);
    while (!(m_line == line && m_cycle == cycle)) @(negedge clk_col4x_pal);
  endtask

  task automatic test_strobes();
    repeat (3) @(negedge clk_col4x_pal);
    sync_chk = 1;
    if (irq !== 1'b1) note_fail("irq", irq, 1);
    repeat (64) begin
      @(negedge clk_col4x_pal);
      checks++;
      if (clk_phi !== (m_tick >= 16)) note_fail("clk_phi", clk_phi, m_tick >= 16);
      if (aec !== (m_tick < 16)) note_fail("aec", aec, m_tick < 16);
      if (ras !== !((m_tick >= 4 && m_tick <= 15) || m_tick >= 20))
        note_fail("ras", ras, !((m_tick >= 4 && m_tick <= 15) || m_tick >= 20));
      if (cas !== !((m_tick >= 8 && m_tick <= 15) || m_tick >= 24))
        note_fail("cas", cas, !((m_tick >= 8 && m_tick <= 15) || m_tick >= 24));
      if (ls245_addr_dir !== 1'b0) note_fail("ls245_addr_dir", ls245_addr_dir, 0);
      if (ls245_data_dir !== 1'b0) note_fail("ls245_data_dir", ls245_data_dir, 0);
    end
  endtask

  task automatic test_readback();
    logic [5:0] addrs [5] = '{`REG_BORDER, `REG_BG, `REG_BASE, `REG_CTRL, `REG_IRQ_EN};
    logic [7:0] masks [5] = '{8'h0f, 8'h0f, 8'hf0, 8'h90, 8'h01};
    logic [7:0] v, r;
    for (int i = 0; i < 5; i++) begin
      v = $random(seed);
      write_reg(addrs[i], v);
      read_reg(addrs[i], r);
      checks++;
      if (r !== (v & masks[i])) note_fail($sformatf("reg_%h", addrs[i]), r, v & masks[i]);
    end
    write_reg(`REG_CTRL, 8'h00);          // display off, compare bit 8 clear
  endtask

  task automatic test_irq();
    write_reg(`REG_RASTER, 8'd5);
    write_reg(`REG_IRQ_EN, 8'h01);
    wait_pos(4, 40);
    if (irq !== 1'b1) note_fail("irq", irq, 1);
    wait_pos(5, 2);
    checks++;
    if (irq !== 1'b0) note_fail("irq", irq, 0);
    write_reg(`REG_IRQ_STAT, 8'h01);      // ack
    if (irq !== 1'b1) note_fail("irq", irq, 1);
    write_reg(`REG_IRQ_EN, 8'h00);
    write_reg(`REG_RASTER, 8'd7);
    wait_pos(7, 10);
    checks++;
    if (irq !== 1'b1) note_fail("irq", irq, 1);
  endtask

  task automatic test_border_only();
    write_reg(`REG_BORDER, $random(seed));
    wait_pos(52, 0);                      // lines inside the window
    pix_chk = 1;
    wait_pos(55, 0);
    pix_chk = 0;
  endtask

  task automatic test_display();
    write_reg(`REG_BG, $random(seed));
    write_reg(`REG_BASE, $random(seed));
    write_reg(`REG_CTRL, 8'h10);          // display on
    wait_pos(60, 0);
    pix_chk = 1;
    wait_pos(62, 0);
  endtask

  task automatic test_raster_read();
    logic [7:0] r;
    repeat (2) begin
      read_reg(`REG_RASTER, r);
      checks++;
      if (r !== vs_line[7:0]) note_fail("raster", r, vs_line[7:0]);
      wait_pos(m_line + 2, 20);
    end
  endtask

  initial begin
    {rst_n, ce, rw, lp, addr_drive, data_drive, cpu_addr, cpu_data} = {6'b011100, 14'h0};
    repeat (2) @(posedge clk_col4x_pal);
    #2 rst_n = 1;
    test_strobes();
    test_readback();
    test_irq();
    test_border_only();
    test_display();
    test_raster_read();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin // two frames plus margin
    #(2 * FRAME_NS + 1_000_000);
    $display("timeout: the tests did not finish within two frames");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/vic_assertions.sv ====
`default_nettype none

module vic_assertions (
  input wire       clk_col4x_pal,
  input wire       rst_n,
  input wire [4:0] tick,
  input wire       clk_phi,
  input wire       ras,
  input wire       cas,
  input wire       vic_write_ab
);

  timeunit 1ns;
  timeprecision 1ps;

  // ras has been open for at least a clock when cas falls
  cas_under_ras: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    $fell(cas) |-> $past(!ras))
    else $error("cas fell while ras was still high");

  // the vic owns the address bus only in ticks 0 to 15
  ab_in_vic_half: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    !(vic_write_ab && tick[4]))
    else $error("vic drove the address bus in the cpu half");

  // phi only moves on the half-cycle boundaries
  phi_stable: assert property (@(posedge clk_col4x_pal) disable iff (!rst_n)
    (tick != 5'd0 && tick != 5'd16) |-> $stable(clk_phi))
    else $error("clk_phi changed inside a half cycle");

endmodule

bind bus_sequencer vic_assertions u_sva (
  .clk_col4x_pal (clk_col4x_pal),
  .rst_n         (rst_n),
  .tick          (pos.tick),
  .clk_phi       (clk_phi),
  .ras           (ras),
  .cas           (cas),
  .vic_write_ab  (vic_write_ab)
);

`default_nettype wire

// ==== src/vic_board_top.sv ====
`default_nettype none

module vic_board_top (
  input  wire       clk_col4x_pal,   // used directly as dot4x
  input  wire       rst_n,
  input  wire       ce,              // low = chip selected
  input  wire       rw,              // high = read
  input  wire       lp,              // light pen, not modeled
  input  wire [3:0] dbh,             // color ram nibble
  inout  wire [5:0] adl,
  inout  wire [7:0] dbl,
  output wire [5:0] adh,
  output wire       clk_phi,
  output wire       aec,
  output wire       ras,
  output wire       cas,
  output wire       irq,
  output wire       ls245_addr_dir,
  output wire       ls245_data_dir,
  output wire [5:0] red,
  output wire [5:0] green,
  output wire [5:0] blue,
  output wire       hsync,
  output wire       vsync,
  output wire       active
);

  import vic_pkg::*;

  cpu_bus_t    bus_raw;
  cpu_bus_t    bus_sync;
  raster_pos_t pos;
  vic_regs_t   regs;
  fetch_t      fetch;
  rgb_t        pix;
  sync_t       sync_q;
  logic        raster_hit;
  logic        cpu_sel;
  logic        fetch_stb;
  logic        vic_write_ab;
  logic        vic_write_db;
  logic [11:0] ado;
  logic [7:0]  dbo;

  assign bus_raw = '{ce: ce, rw: rw, addr: adl, data: dbl}; // raw pin sample

  // two flop synchronizer for the async cpu pins
  video_delay #(.payload_t(cpu_bus_t), .DEPTH(2)) u_bus_sync (
    .clk_col4x_pal (clk_col4x_pal), .rst_n (rst_n), .d (bus_raw), .q (bus_sync)
  );

  raster_timer u_timer (
    .clk_col4x_pal, .rst_n, .raster_cmp (regs.raster_cmp), .pos, .raster_hit
  );

  bus_sequencer u_seq (
    .clk_col4x_pal, .rst_n, .pos, .regs, .dbi ({dbh, dbl}), .ado, .vic_write_ab,
    .clk_phi, .aec, .ras, .cas, .ls245_addr_dir, .cpu_sel, .fetch_stb, .fetch
  );

  vic_registers u_regs (
    .clk_col4x_pal, .rst_n, .bus (bus_sync), .cpu_sel, .raster_hit, .line (pos.line),
    .regs, .dbo, .vic_write_db, .irq
  );

  pixel_unit u_pix (
    .clk_col4x_pal, .rst_n, .pos, .regs, .fetch_stb, .fetch, .pix, .sync (sync_q)
  );

  // tri-state pins, released whenever the vic is not the bus master
  assign adl = vic_write_ab ? ado[5:0]  : 6'bz;
  assign adh = vic_write_ab ? ado[11:6] : 6'bz;
  assign dbl = vic_write_db ? dbo       : 8'bz;  // cpu read
  assign ls245_data_dir = vic_write_db;

  assign red    = pix.red;
  assign green  = pix.green;
  assign blue   = pix.blue;
  assign hsync  = sync_q.hsync;
  assign vsync  = sync_q.vsync;
  assign active = sync_q.active;

endmodule

`default_nettype wire

// ==== src/pixel_unit.sv ====
`default_nettype none

`include "vic_config.svh"

module pixel_unit (
  input  wire                       clk_col4x_pal,
  input  wire                       rst_n,
  input  wire vic_pkg::raster_pos_t pos,
  input  wire vic_pkg::vic_regs_t   regs,
  input  wire                       fetch_stb,
  input  wire vic_pkg::fetch_t      fetch,
  output vic_pkg::rgb_t             pix,
  output vic_pkg::sync_t            sync
);

  import vic_pkg::*;

  fetch_t     next_cell;    // fetched this cycle, shown next cycle
  logic       next_valid;
  logic       shown_valid;  // shifter holds a real cell
  logic [7:0] shift_q;
  logic [3:0] color_q;
  logic       cycle_end;
  logic       pix_step;
  logic       border_sel;
  logic [3:0] idx;
  logic [3:0] idx_q;
  sync_t      sync_now;

  assign cycle_end = pos.tick == 5'(`CYCLE_TICKS - 1);
  assign pix_step  = pos.tick[1:0] == 2'b11;         // 4 ticks per pixel

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      next_valid  <= 1'b0;
      shown_valid <= 1'b0;
    end else begin
      if (cycle_end) begin
        shown_valid <= next_valid;
        next_valid  <= 1'b0;
      end
      if (fetch_stb) next_valid <= 1'b1;               // tick 15, never at cycle end
    end
  end

  always_ff @(posedge clk_col4x_pal) begin
    if (fetch_stb) next_cell <= fetch;
    if (cycle_end) begin
      shift_q <= next_cell.char_data;                // msb shows first
      color_q <= next_cell.color;
    end else if (pix_step) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign border_sel = !shown_valid || !regs.den;
  assign idx = border_sel ? regs.border : (shift_q[7] ? color_q : regs.bg);

  // two stages: index register, then palette register
  always_ff @(posedge clk_col4x_pal) begin
    idx_q <= idx;
    pix   <= palette[idx_q];
  end

  always_comb begin
    sync_now.hsync  = !(pos.cycle < 6'(`HSYNC_CYCLES));
    sync_now.vsync  = !(pos.line < 9'(`VSYNC_LINES));
    sync_now.active = sync_now.hsync && sync_now.vsync;  // outside both pulses
    sync_now.border = border_sel;
  end

  // sync rides the same number of clocks as the color path
  video_delay #(
    .payload_t (sync_t),
    .DEPTH     (`PIX_LATENCY)
  ) u_sync_dly (
    .clk_col4x_pal (clk_col4x_pal),
    .rst_n         (rst_n),
    .d             (sync_now),
    .q             (sync)
  );

endmodule

`default_nettype wire

// ==== src/vic_registers.sv ====
`default_nettype none

`include "vic_config.svh"

module vic_registers (
  input  wire                     clk_col4x_pal,
  input  wire                     rst_n,
  input  wire vic_pkg::cpu_bus_t  bus,         // synchronized pins
  input  wire                     cpu_sel,
  input  wire                     raster_hit,
  input  wire [8:0]               line,
  output vic_pkg::vic_regs_t      regs,
  output logic [7:0]              dbo,
  output logic                    vic_write_db,
  output logic                    irq          // active low
);

  localparam logic [3:0] RD_SLOT  = 4'd3;   // tick 19, sample has settled
  localparam logic [3:0] WR_SLOT  = 4'd12;  // tick 28
  localparam logic [3:0] END_SLOT = 4'd15;  // tick 31

  logic [3:0] slot;       // tick minus 16 inside the cpu half
  logic [7:0] rd_data;
  logic       wr_now;
  logic       irq_stat;
  logic       irq_en;

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      slot <= 4'd0;
    end else begin
      slot <= cpu_sel ? slot + 4'd1 : 4'd0;
    end
  end

  always_comb begin
    case (bus.addr)
      `REG_CTRL:     rd_data = {regs.raster_cmp[8], 2'b00, regs.den, 4'b0000};
      `REG_RASTER:   rd_data = line[7:0];                  // live beam line
      `REG_BASE:     rd_data = {regs.base, 4'b0000};
      `REG_IRQ_STAT: rd_data = {!irq, 6'b000000, irq_stat};
      `REG_IRQ_EN:   rd_data = {7'b0000000, irq_en};
      `REG_BORDER:   rd_data = {4'b0000, regs.border};
      `REG_BG:       rd_data = {4'b0000, regs.bg};
      default:       rd_data = 8'hff;
    endcase
  end

  // read: drive dbo from tick 20 through tick 31
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      vic_write_db <= 1'b0;
    end else if (cpu_sel && slot == RD_SLOT) begin
      vic_write_db <= !bus.ce && bus.rw;
    end else if (slot == END_SLOT) begin
      vic_write_db <= 1'b0;
    end
  end

  always_ff @(posedge clk_col4x_pal) begin
    if (cpu_sel && slot == RD_SLOT) dbo <= rd_data; // held for the rest of the half
  end

  assign wr_now = cpu_sel && (slot == WR_SLOT) && !bus.ce && !bus.rw;

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      regs     <= '0;
      irq_stat <= 1'b0;
      irq_en   <= 1'b0;
    end else begin
      if (wr_now) begin
        case (bus.addr)
          `REG_CTRL: begin
            regs.raster_cmp[8] <= bus.data[7];
            regs.den           <= bus.data[4];
          end
          `REG_RASTER:   regs.raster_cmp[7:0] <= bus.data;
          `REG_BASE:     regs.base   <= bus.data[7:4];
          `REG_IRQ_STAT: if (bus.data[0]) irq_stat <= 1'b0; // write 1 to ack
          `REG_IRQ_EN:   irq_en      <= bus.data[0];
          `REG_BORDER:   regs.border <= bus.data[3:0];
          `REG_BG:       regs.bg     <= bus.data[3:0];
          default: ;
        endcase
      end
      if (raster_hit) irq_stat <= 1'b1; // a new hit beats a same-clock ack
    end
  end

  assign irq = !(irq_stat && irq_en);

endmodule

`default_nettype wire

// ==== src/bus_sequencer.sv ====
`default_nettype none

`include "vic_config.svh"

module bus_sequencer (
  input  wire                  clk_col4x_pal,
  input  wire                  rst_n,
  input  wire vic_pkg::raster_pos_t pos,
  input  wire vic_pkg::vic_regs_t   regs,
  input  wire [11:0]           dbi,            // {dbh, dbl}
  output logic [11:0]          ado,
  output logic                 vic_write_ab,
  output logic                 clk_phi,
  output logic                 aec,
  output logic                 ras,
  output logic                 cas,
  output logic                 ls245_addr_dir,
  output logic                 cpu_sel,        // cpu half of the cycle
  output logic                 fetch_stb,
  output vic_pkg::fetch_t      fetch
);

  import vic_pkg::*;

  typedef enum logic [2:0] {
    IDLE, VIC_ADDR, VIC_RAS, VIC_CAS, CPU_ADDR, CPU_RAS, CPU_CAS
  } phase_e;

  phase_e     state;
  logic [4:0] tick_next;
  logic       in_win;
  logic       fetching;
  logic       vic_half;
  logic [7:0] cell_idx;   // cell index within the frame

  // tick -> phase, each half is addr / ras / cas
  function automatic phase_e phase_of(input logic [4:0] t);
    phase_e p;
    case (t[3:2])
      2'd0:    p = t[4] ? CPU_ADDR : VIC_ADDR;
      2'd1:    p = t[4] ? CPU_RAS  : VIC_RAS;
      default: p = t[4] ? CPU_CAS  : VIC_CAS;
    endcase
    return p;
  endfunction

  assign tick_next = (pos.tick == 5'(`CYCLE_TICKS - 1)) ? 5'd0 : pos.tick + 5'd1;

  // state is loaded from the next tick so it lines up with pos
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= phase_of(tick_next);
    end
  end

  assign vic_half = (state == IDLE) || (state == VIC_ADDR) || (state == VIC_RAS) ||
                    (state == VIC_CAS);
  assign clk_phi  = !vic_half;             // low while the vic owns the bus
  assign aec      = !clk_phi;
  assign ras      = (state == IDLE) || (state == VIC_ADDR) || (state == CPU_ADDR);
  assign cas      = !((state == VIC_CAS) || (state == CPU_CAS));
  assign cpu_sel  = clk_phi;

  assign in_win = (pos.cycle >= 6'(`WIN_FIRST_CYCLE)) && (pos.cycle <= 6'(`WIN_LAST_CYCLE)) &&
                  (pos.line  >= 9'(`WIN_FIRST_LINE))  && (pos.line  <= 9'(`WIN_LAST_LINE));
  assign fetching = in_win && regs.den;

  assign vic_write_ab   = fetching && vic_half;
  assign ls245_addr_dir = vic_write_ab;                // transceiver points at the bus
  assign ado            = {regs.base, cell_idx};
  assign fetch_stb      = fetching && (pos.tick == 5'd15); // last vic tick

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      cell_idx <= 8'd0;
    end else if (pos == '0) begin
      cell_idx <= 8'd0;             // frame start
    end else if (fetch_stb) begin
      cell_idx <= cell_idx + 8'd1;
    end
  end

  // follow the bus while the fetch address is out; value at tick 15 is the cell
  always_ff @(posedge clk_col4x_pal) begin
    if (vic_write_ab) begin
      fetch.char_data <= dbi[7:0];
      fetch.color     <= dbi[11:8];
    end
  end

endmodule

`default_nettype wire

// ==== src/video_delay.sv ====
`default_nettype none

module video_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2      // clocks from d to q
) (
  input  wire      clk_col4x_pal,
  input  wire      rst_n,
  input  wire      payload_t d,
  output payload_t q
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      stage <= '{default: payload_t'('0)};
    end else begin
      stage[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1]; // one register per clock of delay
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/raster_timer.sv ====
`default_nettype none

`include "vic_config.svh"

module raster_timer (
  input  wire                  clk_col4x_pal,
  input  wire                  rst_n,
  input  wire [8:0]            raster_cmp,  // compare line from the register file
  output vic_pkg::raster_pos_t pos,
  output logic                 raster_hit   // one clock, tick 0 / cycle 0 of the matching line
);

  logic       tick_wrap;
  logic       cycle_wrap;
  logic       line_wrap;
  logic [8:0] line_next;

  assign tick_wrap  = pos.tick  == 5'(`CYCLE_TICKS - 1);
  assign cycle_wrap = pos.cycle == 6'(`LINE_CYCLES - 1);
  assign line_wrap  = pos.line  == 9'(`FRAME_LINES - 1);

  // line number that the next line start will carry
  assign line_next = line_wrap ? 9'd0 : pos.line + 9'd1;

  // chained counters: tick -> cycle -> line
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      pos <= '0;
    end else begin
      if (tick_wrap) begin
        pos.tick <= 5'd0;
        if (cycle_wrap) begin
          pos.cycle <= 6'd0;
          pos.line  <= line_next; // wraps at frame end
        end else begin
          pos.cycle <= pos.cycle + 6'd1;
        end
      end else begin
        pos.tick <= pos.tick + 5'd1;
      end
    end
  end

  // compare is taken one clock early so the pulse lines up with
  // the first tick of the new line
  always_ff @(posedge clk_col4x_pal) begin
    if (!rst_n) begin
      raster_hit <= 1'b0;
    end else begin
      raster_hit <= tick_wrap && cycle_wrap && (line_next == raster_cmp);
    end
  end

endmodule

`default_nettype wire

// ==== src/vic_pkg.sv ====
`default_nettype none

package vic_pkg;

  // beam position
  typedef struct packed {
    logic [4:0] tick;   // dot4x tick inside the bus cycle
    logic [5:0] cycle;  // bus cycle inside the line
    logic [8:0] line;   // raster line
  } raster_pos_t;

  // one sampled cpu bus word
  typedef struct packed {
    logic       ce;     // low = selected
    logic       rw;     // high = read
    logic [5:0] addr;
    logic [7:0] data;
  } cpu_bus_t;

  // register values used outside the register file
  typedef struct packed {
    logic       den;        // display enable
    logic [8:0] raster_cmp;
    logic [3:0] base;       // screen base, lands on adh[5:2]
    logic [3:0] border;
    logic [3:0] bg;
  } vic_regs_t;

  typedef struct packed {
    logic [7:0] char_data;
    logic [3:0] color;      // color ram nibble from dbh
  } fetch_t;

  typedef struct packed {
    logic hsync;   // active low
    logic vsync;   // active low
    logic active;
    logic border;
  } sync_t;

  typedef struct packed {
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;
  } rgb_t;

  // 16 color palette, 6 bits per gun
  localparam rgb_t palette [16] = '{
    '{6'h00, 6'h00, 6'h00}, '{6'h3f, 6'h3f, 6'h3f}, '{6'h1a, 6'h0d, 6'h0a},
    '{6'h1c, 6'h29, 6'h2d}, '{6'h1b, 6'h0f, 6'h22}, '{6'h16, 6'h23, 6'h11},
    '{6'h0d, 6'h0a, 6'h1c}, '{6'h2f, 6'h31, 6'h1d}, '{6'h1b, 6'h14, 6'h0a},
    '{6'h11, 6'h0e, 6'h00}, '{6'h26, 6'h19, 6'h16}, '{6'h11, 6'h11, 6'h11},
    '{6'h1b, 6'h1b, 6'h1b}, '{6'h26, 6'h35, 6'h21}, '{6'h1b, 6'h17, 6'h2e},
    '{6'h25, 6'h25, 6'h25}
  };

endpackage

`default_nettype wire

// ==== src/vic_config.svh ====
`ifndef VIC_CONFIG_SVH
`define VIC_CONFIG_SVH

// beam timing, all counts in dot4x ticks / bus cycles / raster lines
`define CYCLE_TICKS      32   // ticks 0..15 vic half, 16..31 cpu half
`define LINE_CYCLES      63   // pal line
`define FRAME_LINES      312  // pal frame

// display window, inclusive bounds
`define WIN_FIRST_CYCLE  16
`define WIN_LAST_CYCLE   55
`define WIN_FIRST_LINE   51
`define WIN_LAST_LINE    250

// sync pulses, active low from cycle 0 / line 0
`define HSYNC_CYCLES     4
`define VSYNC_LINES      3

`define PIX_LATENCY      2    // shifter to registered rgb

// register map on the 6 bit cpu address
`define REG_CTRL         6'h11
`define REG_RASTER       6'h12
`define REG_BASE         6'h18
`define REG_IRQ_STAT     6'h19
`define REG_IRQ_EN       6'h1A
`define REG_BORDER       6'h20
`define REG_BG           6'h21

`endif
